/* src/regfile_pkg.sv */
`default_nettype none

package regfile_pkg;

   // array geometry
   localparam int NUM_WORDS   = 64;
   localparam int NUM_GROUPS  = 4;
   localparam int GROUP_WORDS = NUM_WORDS / NUM_GROUPS;

   localparam int ADDR_W = 6;
   localparam int DATA_W = 24;

   // bit 0 is the msb, as in the subarray pin numbering
   typedef logic [0:ADDR_W-1] addr_t;

   typedef logic [0:DATA_W-1] data_t;

   // one word line per word of a group, index equals word offset
   typedef logic [0:GROUP_WORDS-1] wordline_t;

   typedef struct packed {
      logic  en;
      addr_t addr;
   } rd_req_t;

   typedef struct packed {
      logic  en;
      addr_t addr;
      data_t data;
   } wr_req_t;

   // one-hot address groups
   // half: a0 low/high
   // a12:  {a1,a2} = 00, 01, 10, 11
   // a3:   a3 low/high
   // a45:  {a4,a5} = 00, 01, 10, 11
   // all group fields are zero while en is low
   typedef struct packed {
      logic       en;
      logic [0:1] half;
      logic [0:3] a12;
      logic [0:1] a3;
      logic [0:3] a45;
   } predecode_t;

   // read bit lines of one group, zero when the group is not selected
   typedef struct packed {
      data_t rbl0;
      data_t rbl1;
      logic  hit0;
      logic  hit1;
   } group_rd_t;

endpackage

`default_nettype wire

/* src/addr_predecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module addr_predecoder (
   input  wire                     clk,
   input  wire                     rst_n,
   input  wire                     en,
   input  wire regfile_pkg::addr_t addr,
   output regfile_pkg::predecode_t pd
);

   logic               en_q;
   regfile_pkg::addr_t addr_q;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         en_q <= 1'b0;
      end else begin
         en_q <= en;
      end
   end

   // address only matters while en_q is set
   always_ff @(posedge clk) begin
      if (en) begin
         addr_q <= addr;
      end
   end

   // expand the registered address into the one-hot groups
   always_comb begin
      pd    = '0;
      pd.en = en_q;
      if (en_q) begin
         pd.half[addr_q[0]]  = 1'b1;
         pd.a12[addr_q[1:2]] = 1'b1;
         pd.a3[addr_q[3]]    = 1'b1;
         pd.a45[addr_q[4:5]] = 1'b1;
      end
   end

   // a request taken at one edge shows up as a full one-hot decode at the next
   assert property (@(posedge clk) disable iff (!rst_n)
                    en |=> (pd.en && $onehot(pd.half) && $onehot(pd.a12) &&
                            $onehot(pd.a3) && $onehot(pd.a45)))
      else $error("predecode not one-hot one cycle after request");

endmodule

`default_nettype wire

/* src/word_group.sv */
`timescale 1ns/1ps
`default_nettype none

module word_group #(
   parameter int GROUP = 0
) (
   input  wire                          clk,
   input  wire regfile_pkg::predecode_t wr_pd,
   input  wire regfile_pkg::predecode_t rd0_pd,
   input  wire regfile_pkg::predecode_t rd1_pd,
   input  wire regfile_pkg::data_t      wr_data,
   output regfile_pkg::group_rd_t       grp_rd
);

   // group GROUP holds words 16*GROUP to 16*GROUP+15
   // address bit 0 picks the half, bit 1 the group inside it
   localparam bit SEL_A0 = ((GROUP / 2) % 2) != 0;
   localparam bit SEL_A1 = (GROUP % 2) != 0;

   regfile_pkg::data_t     mem [0:regfile_pkg::GROUP_WORDS-1];
   regfile_pkg::wordline_t wwl;
   regfile_pkg::wordline_t rwl0;
   regfile_pkg::wordline_t rwl1;

   // word w of the group: bit 3 of w is a2, bit 2 is a3, bits 1:0 are a4/a5
   function automatic regfile_pkg::wordline_t wordline(
      input regfile_pkg::predecode_t p
   );
      regfile_pkg::wordline_t wl;
      for (int w = 0; w < regfile_pkg::GROUP_WORDS; w++) begin
         wl[w] = p.half[SEL_A0] &
                 p.a12[{SEL_A1, w[3]}] &
                 p.a3[w[2]] &
                 p.a45[w[1:0]];
      end
      return wl;
   endfunction

   assign wwl  = wordline(wr_pd);
   assign rwl0 = wordline(rd0_pd);
   assign rwl1 = wordline(rd1_pd);

   always_ff @(posedge clk) begin
      for (int w = 0; w < regfile_pkg::GROUP_WORDS; w++) begin
         if (wwl[w]) begin
            mem[w] <= wr_data;
         end
      end
   end

   // read bit lines, a wired OR of the selected cells
   always_comb begin
      grp_rd.rbl0 = '0;
      grp_rd.rbl1 = '0;
      for (int w = 0; w < regfile_pkg::GROUP_WORDS; w++) begin
         grp_rd.rbl0 = grp_rd.rbl0 | (mem[w] & {regfile_pkg::DATA_W{rwl0[w]}});
         grp_rd.rbl1 = grp_rd.rbl1 | (mem[w] & {regfile_pkg::DATA_W{rwl1[w]}});
      end
      grp_rd.hit0 = |rwl0;
      grp_rd.hit1 = |rwl1;
   end

   // holds only if the predecoders deliver clean one-hot groups
   assert property (@(posedge clk)
                    !$isunknown({wwl, rwl0, rwl1}) |->
                    ($onehot0(wwl) && $onehot0(rwl0) && $onehot0(rwl1)))
      else $error("group %0d has more than one word line active", GROUP);

endmodule

`default_nettype wire

/* src/bitline_merge.sv */
`timescale 1ns/1ps
`default_nettype none

module bitline_merge (
   input  wire                         clk,
   input  wire                         rst_n,
   input  wire regfile_pkg::group_rd_t grp_rd [0:regfile_pkg::NUM_GROUPS-1],
   output regfile_pkg::data_t          rd0_dat,
   output regfile_pkg::data_t          rd1_dat
);

   regfile_pkg::data_t                  rbl0_or;
   regfile_pkg::data_t                  rbl1_or;
   logic [0:regfile_pkg::NUM_GROUPS-1] hit0;
   logic [0:regfile_pkg::NUM_GROUPS-1] hit1;

   // unselected groups drive zero, so a plain OR merges them
   always_comb begin
      rbl0_or = '0;
      rbl1_or = '0;
      for (int g = 0; g < regfile_pkg::NUM_GROUPS; g++) begin
         rbl0_or = rbl0_or | grp_rd[g].rbl0;
         rbl1_or = rbl1_or | grp_rd[g].rbl1;
         hit0[g] = grp_rd[g].hit0;
         hit1[g] = grp_rd[g].hit1;
      end
   end

   // output latch, holds while its port is idle
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rd0_dat <= '0;
         rd1_dat <= '0;
      end else begin
         if (|hit0) begin
            rd0_dat <= rbl0_or;
         end
         if (|hit1) begin
            rd1_dat <= rbl1_or;
         end
      end
   end

   // the four groups decode disjoint address ranges
   assert property (@(posedge clk) disable iff (!rst_n)
                    $onehot0(hit0) && $onehot0(hit1))
      else $error("more than one word group selected on a read port");

endmodule

`default_nettype wire

/* src/regfile_2r1w_64x24.sv */
`timescale 1ns/1ps
`default_nettype none

module regfile_2r1w_64x24 (
   input  wire                       clk,
   input  wire                       rst_n,
   input  wire regfile_pkg::rd_req_t rd0_req,
   input  wire regfile_pkg::rd_req_t rd1_req,
   input  wire regfile_pkg::wr_req_t wr0_req,
   output regfile_pkg::data_t        rd0_dat,
   output regfile_pkg::data_t        rd1_dat
);

   regfile_pkg::predecode_t rd0_pd;
   regfile_pkg::predecode_t rd1_pd;
   regfile_pkg::predecode_t wr_pd;
   regfile_pkg::data_t      wr0_dat_q;

   wire regfile_pkg::group_rd_t grp_rd [0:regfile_pkg::NUM_GROUPS-1];

   addr_predecoder u_rd0_pd (
      .clk   (clk),
      .rst_n (rst_n),
      .en    (rd0_req.en),
      .addr  (rd0_req.addr),
      .pd    (rd0_pd)
   );

   addr_predecoder u_rd1_pd (
      .clk   (clk),
      .rst_n (rst_n),
      .en    (rd1_req.en),
      .addr  (rd1_req.addr),
      .pd    (rd1_pd)
   );

   addr_predecoder u_wr_pd (
      .clk   (clk),
      .rst_n (rst_n),
      .en    (wr0_req.en),
      .addr  (wr0_req.addr),
      .pd    (wr_pd)
   );

   // write data stays aligned with the registered write address
   always_ff @(posedge clk) begin
      if (wr0_req.en) begin
         wr0_dat_q <= wr0_req.data;
      end
   end

   for (genvar g = 0; g < regfile_pkg::NUM_GROUPS; g++) begin : g_group
      word_group #(
         .GROUP (g)
      ) u_word_group (
         .clk     (clk),
         .wr_pd   (wr_pd),
         .rd0_pd  (rd0_pd),
         .rd1_pd  (rd1_pd),
         .wr_data (wr0_dat_q),
         .grp_rd  (grp_rd[g])
      );
   end

   bitline_merge u_bitline_merge (
      .clk     (clk),
      .rst_n   (rst_n),
      .grp_rd  (grp_rd),
      .rd0_dat (rd0_dat),
      .rd1_dat (rd1_dat)
   );

endmodule

`default_nettype wire

/* verification/tb_lfsr.svh */
`ifndef TB_LFSR_SVH
`define TB_LFSR_SVH

// 16-bit fibonacci lfsr, x^16 + x^15 + x^13 + x^4 + 1
localparam logic [15:0] LFSR_SEED = 16'd61030;

logic [15:0] lfsr_state = LFSR_SEED;

function automatic logic [15:0] lfsr_next(input logic [15:0] s);
   logic fb;
   fb = s[15] ^ s[14] ^ s[12] ^ s[3];
   return {s[14:0], fb};
endfunction

// one lfsr step per bit, the first bit drawn ends up as the msb
function automatic logic [31:0] draw_bits(input int n);
   logic [31:0] r;
   r = '0;
   for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
   end
   return r;
endfunction

function automatic logic draw_bit();
   logic [31:0] r;
   r = draw_bits(1);
   return r[0];
endfunction

`endif

/* verification/tb_regfile_2r1w_64x24.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_regfile_2r1w_64x24;

   localparam int CLK_PERIOD    = 40;
   localparam int HALF_PERIOD   = CLK_PERIOD / 2;
   localparam int DRIVE_DELAY   = 2;
   localparam int RESET_CYCLES  = 10;
   localparam int RANDOM_CYCLES = 2000;
   // reset, fill and read-back of every word, random traffic, plus slack
   localparam int TIMEOUT_CYCLES = RESET_CYCLES + 2 * regfile_pkg::NUM_WORDS +
                                   RANDOM_CYCLES + 100;

   logic                 clk;
   logic                 rst_n;
   regfile_pkg::rd_req_t rd0_req;
   regfile_pkg::rd_req_t rd1_req;
   regfile_pkg::wr_req_t wr0_req;
   regfile_pkg::data_t   rd0_dat;
   regfile_pkg::data_t   rd1_dat;

   `include "tb_lfsr.svh"

   // reference model of the array and the port pipelines
   regfile_pkg::data_t model_mem [0:regfile_pkg::NUM_WORDS-1];
   logic               pend_rd0_en;
   logic               pend_rd1_en;
   regfile_pkg::data_t pend_rd0;
   regfile_pkg::data_t pend_rd1;
   logic               pend_wr_en;
   regfile_pkg::addr_t pend_wr_addr;
   regfile_pkg::data_t pend_wr_data;
   regfile_pkg::data_t exp_rd0;
   regfile_pkg::data_t exp_rd1;

   int errors;
   int checks;
   int cycle_count;

   regfile_2r1w_64x24 UUT (
      .clk     (clk),
      .rst_n   (rst_n),
      .rd0_req (rd0_req),
      .rd1_req (rd1_req),
      .wr0_req (wr0_req),
      .rd0_dat (rd0_dat),
      .rd1_dat (rd1_dat)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #HALF_PERIOD;
         clk = ~clk;
      end
   end

   function automatic regfile_pkg::data_t rand_data();
      logic [31:0] r;
      r = draw_bits(regfile_pkg::DATA_W);
      return r[regfile_pkg::DATA_W-1:0];
   endfunction

   function automatic regfile_pkg::addr_t rand_addr();
      logic [31:0] r;
      r = draw_bits(regfile_pkg::ADDR_W);
      return r[regfile_pkg::ADDR_W-1:0];
   endfunction

   task automatic check_data(input string name, input regfile_pkg::data_t got,
                             input regfile_pkg::data_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[FAIL] t=%0d ns %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic drive_reads(input logic en0, input regfile_pkg::addr_t addr0,
                              input logic en1, input regfile_pkg::addr_t addr1);
      rd0_req.en   = en0;
      rd0_req.addr = addr0;
      rd1_req.en   = en1;
      rd1_req.addr = addr1;
   endtask

   task automatic drive_write(input logic en, input regfile_pkg::addr_t addr,
                              input regfile_pkg::data_t data);
      wr0_req.en   = en;
      wr0_req.addr = addr;
      wr0_req.data = data;
   endtask

   task automatic drive_idle();
      drive_reads(1'b0, '0, 1'b0, '0);
      drive_write(1'b0, '0, '0);
   endtask

   // called just after an edge, with the inputs that edge sampled still applied
   task automatic update_model();
      if (!rst_n) begin
         exp_rd0     = '0;
         exp_rd1     = '0;
         pend_rd0_en = 1'b0;
         pend_rd1_en = 1'b0;
         pend_wr_en  = 1'b0;
      end else begin
         // output latch takes the reads sampled one edge earlier
         if (pend_rd0_en) begin
            exp_rd0 = pend_rd0;
         end
         if (pend_rd1_en) begin
            exp_rd1 = pend_rd1;
         end
         // write sampled one edge earlier lands now, before this edge's reads
         if (pend_wr_en) begin
            model_mem[pend_wr_addr] = pend_wr_data;
         end
         pend_rd0_en  = rd0_req.en;
         pend_rd0     = model_mem[rd0_req.addr];
         pend_rd1_en  = rd1_req.en;
         pend_rd1     = model_mem[rd1_req.addr];
         pend_wr_en   = wr0_req.en;
         pend_wr_addr = wr0_req.addr;
         pend_wr_data = wr0_req.data;
      end
   endtask

   task automatic next_cycle();
      @(posedge clk);
      #DRIVE_DELAY;
      update_model();
      check_data("rd0_dat", rd0_dat, exp_rd0);
      check_data("rd1_dat", rd1_dat, exp_rd1);
   endtask

   // every word line of every group, then read back on both ports
   task automatic fill_and_read_all();
      regfile_pkg::addr_t a0;
      regfile_pkg::addr_t a1;
      int                 b;
      for (int a = 0; a < regfile_pkg::NUM_WORDS; a++) begin
         a0 = a[regfile_pkg::ADDR_W-1:0];
         drive_reads(1'b0, '0, 1'b0, '0);
         drive_write(1'b1, a0, rand_data());
         next_cycle();
      end
      drive_write(1'b0, '0, '0);
      for (int a = 0; a < regfile_pkg::NUM_WORDS; a++) begin
         b  = regfile_pkg::NUM_WORDS - 1 - a;
         a0 = a[regfile_pkg::ADDR_W-1:0];
         a1 = b[regfile_pkg::ADDR_W-1:0];
         drive_reads(1'b1, a0, 1'b1, a1);
         next_cycle();
      end
   endtask

   task automatic random_traffic();
      logic               en0;
      logic               en1;
      logic               wen;
      regfile_pkg::addr_t a0;
      regfile_pkg::addr_t a1;
      regfile_pkg::addr_t wa;
      regfile_pkg::data_t wd;
      for (int i = 0; i < RANDOM_CYCLES; i++) begin
         en0 = draw_bit();
         a0  = rand_addr();
         en1 = draw_bit();
         a1  = rand_addr();
         wen = draw_bit();
         wa  = rand_addr();
         wd  = rand_data();
         drive_reads(en0, a0, en1, a1);
         drive_write(wen, wa, wd);
         next_cycle();
      end
   endtask

   task automatic same_edge_conflict();
      regfile_pkg::addr_t a;
      regfile_pkg::data_t old_w;
      regfile_pkg::data_t new_w;
      // let any write still in flight land first
      drive_idle();
      next_cycle();
      a     = rand_addr();
      old_w = model_mem[a];
      new_w = ~old_w;
      drive_write(1'b1, a, new_w);
      drive_reads(1'b1, a, 1'b1, a);
      next_cycle();
      drive_write(1'b0, '0, '0);
      next_cycle();
      check_data("rd0_dat same-edge read", rd0_dat, old_w);
      check_data("rd1_dat same-edge read", rd1_dat, old_w);
      drive_reads(1'b0, '0, 1'b0, '0);
      next_cycle();
      check_data("rd0_dat next-edge read", rd0_dat, new_w);
      check_data("rd1_dat next-edge read", rd1_dat, new_w);
   endtask

   task automatic idle_hold();
      regfile_pkg::addr_t a0;
      regfile_pkg::addr_t a1;
      regfile_pkg::addr_t wa;
      regfile_pkg::data_t held0;
      regfile_pkg::data_t held1;
      a0 = rand_addr();
      a1 = rand_addr();
      drive_write(1'b0, '0, '0);
      drive_reads(1'b1, a0, 1'b1, a1);
      next_cycle();
      drive_reads(1'b0, a0, 1'b0, a1);
      next_cycle();
      held0 = model_mem[a0];
      held1 = model_mem[a1];
      check_data("rd0_dat before idle", rd0_dat, held0);
      check_data("rd1_dat before idle", rd1_dat, held1);
      // overwrite the words just read while both ports stay idle
      for (int i = 0; i < 8; i++) begin
         wa = (i % 2 == 0) ? a0 : a1;
         drive_write(1'b1, wa, rand_data());
         drive_reads(1'b0, rand_addr(), 1'b0, rand_addr());
         next_cycle();
         check_data("rd0_dat while idle", rd0_dat, held0);
         check_data("rd1_dat while idle", rd1_dat, held1);
      end
   endtask

   initial begin
      cycle_count = 0;
      while (cycle_count < TIMEOUT_CYCLES) begin
         @(posedge clk);
         cycle_count++;
      end
      $display("timeout: run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
      $display("Some tests failed");
      $finish;
   end

   initial begin
      errors      = 0;
      checks      = 0;
      rst_n       = 1'b0;
      rd0_req     = '0;
      rd1_req     = '0;
      wr0_req     = '0;
      pend_rd0_en = 1'b0;
      pend_rd1_en = 1'b0;
      pend_wr_en  = 1'b0;
      exp_rd0     = '0;
      exp_rd1     = '0;

      repeat (RESET_CYCLES) begin
         next_cycle();
      end
      rst_n = 1'b1;
      check_data("rd0_dat after reset", rd0_dat, '0);
      check_data("rd1_dat after reset", rd1_dat, '0);

      fill_and_read_all();
      random_traffic();
      same_edge_conflict();
      idle_hold();

      drive_idle();
      next_cycle();
      next_cycle();

      $display("checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* list.f */
+incdir+verification
src/regfile_pkg.sv
src/addr_predecoder.sv
src/word_group.sv
src/bitline_merge.sv
src/regfile_2r1w_64x24.sv
verification/tb_regfile_2r1w_64x24.sv
